//--- hdl/dataMemory.sv
`default_nettype none

module dataMemory #(
    parameter int MEM_WORDS = 256
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire memStagePkg::memCtrl_t memCtrl,
    input  wire memStagePkg::memLen_t  length,
    input  wire memStagePkg::word_t    address,
    input  wire memStagePkg::word_t    storeData,
    input  wire logic                  loadUnsigned,
    input  wire logic                  stopDebug,
    input  wire memStagePkg::word_t    debugAddr,
    output memStagePkg::word_t         loadData,
    output memStagePkg::word_t         debugWord
);

    // Word index width
    localparam int IDX_W = $clog2(MEM_WORDS);

    memStagePkg::word_t mem [MEM_WORDS];

    logic [IDX_W-1:0]   wordIdx;
    logic [1:0]         laneOff;
    memStagePkg::word_t readWord;
    logic [3:0]         byteEn;
    memStagePkg::word_t laneData;
    logic [7:0]         loadByte;
    logic [15:0]        loadHalf;
    memStagePkg::word_t extended;

    // Word address drops the byte offset
    assign wordIdx  = address[IDX_W+1:2];
    assign laneOff  = address[1:0];
    assign readWord = mem[wordIdx];

    //////////////////////////////
    // Store lanes
    //////////////////////////////

    // Little endian, lane 0 is bits 7..0
    always_comb
    begin
        case (length)
            memStagePkg::LEN_BYTE:
            begin
                byteEn   = 4'b0001 << laneOff;
                laneData = {4{storeData[7:0]}};
            end
            memStagePkg::LEN_HALF:
            begin
                // Upper half when offset bit 1 set
                byteEn   = laneOff[1] ? 4'b1100 : 4'b0011;
                laneData = {2{storeData[15:0]}};
            end
            memStagePkg::LEN_WORD:
            begin
                byteEn   = 4'b1111;
                laneData = storeData;
            end
            default:
            begin
                // Reserved code writes nothing
                byteEn   = 4'b0000;
                laneData = storeData;
            end
        endcase
    end

    // Stores are dropped while frozen
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (memCtrl[0] && !stopDebug)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (byteEn[b])
                begin
                    mem[wordIdx][8*b +: 8] <= laneData[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // Load extraction
    //////////////////////////////

    assign loadByte = readWord[8*laneOff +: 8];
    assign loadHalf = laneOff[1] ? readWord[31:16] : readWord[15:0];

    // Sign fill unless unsigned load
    always_comb
    begin
        case (length)
            memStagePkg::LEN_BYTE:
                extended = {{24{~loadUnsigned & loadByte[7]}}, loadByte};
            memStagePkg::LEN_HALF:
                extended = {{16{~loadUnsigned & loadHalf[15]}}, loadHalf};
            default:
                extended = readWord;
        endcase
    end

    // Zero unless a read is requested
    assign loadData = memCtrl[1] ? extended : '0;

    // Debug port reads whole words only
    assign debugWord = mem[debugAddr[IDX_W+1:2]];

endmodule

`default_nettype wire

//--- hdl/debugApbPort.sv
`default_nettype none

module debugApbPort (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  pSel,
    input  wire logic                  pEnable,
    input  wire logic                  pWrite,
    input  wire memStagePkg::apbAddr_t pAddr,
    input  wire memStagePkg::word_t    pWData,
    input  wire memStagePkg::word_t    debugWord,
    output memStagePkg::word_t         pRData,
    output logic                       pReady,
    output logic                       pSlvErr,
    output logic                       stopDebug,
    output memStagePkg::word_t         debugAddr
);

    logic access;
    logic mapped;
    logic badAccess;
    logic regWrite;

    //////////////////////////////
    // Phase and offset decode
    //////////////////////////////

    // Access phase, setup has pEnable low
    assign access = pSel && pEnable;

    assign mapped = (pAddr == memStagePkg::DBG_CTRL) ||
                    (pAddr == memStagePkg::DBG_ADDR) ||
                    (pAddr == memStagePkg::DBG_DATA);

    // Unmapped offset or write to read-only data window
    assign badAccess = !mapped || (pWrite && (pAddr == memStagePkg::DBG_DATA));

    // No wait states
    assign pReady  = access;
    assign pSlvErr = access && badAccess;

    // Register update at end of access
    assign regWrite = access && pWrite && !badAccess;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stopDebug <= 1'b0;
            debugAddr <= '0;
        end
        else if (regWrite)
        begin
            case (pAddr)
                memStagePkg::DBG_CTRL:
                    stopDebug <= pWData[0];
                memStagePkg::DBG_ADDR:
                    debugAddr <= pWData;
                default:
                begin
                end
            endcase
        end
    end

    //////////////////////////////
    // Read data
    //////////////////////////////

    always_comb
    begin
        pRData = '0;
        if (access && !pWrite)
        begin
            case (pAddr)
                memStagePkg::DBG_CTRL:
                    pRData = {31'd0, stopDebug};
                memStagePkg::DBG_ADDR:
                    pRData = debugAddr;
                memStagePkg::DBG_DATA:
                    pRData = debugWord;
                default:
                    pRData = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/memStagePkg.sv
`default_nettype none

package memStagePkg;

    //////////////////////////////
    // Vector types
    //////////////////////////////

    // Data word, address or link address
    typedef logic [31:0] word_t;

    // Register file index
    typedef logic [4:0] regIdx_t;

    // Writeback control bundle
    typedef logic [4:0] wbCtrl_t;

    // Memory control, read on bit 1 and write on bit 0
    typedef logic [1:0] memCtrl_t;

    // Access length code
    typedef logic [1:0] memLen_t;

    // Debug register offset on APB
    typedef logic [3:0] apbAddr_t;

    //////////////////////////////
    // Writeback control fields
    //////////////////////////////

    localparam int WB_REG_WRITE  = 4;
    // Two-bit length field starts here
    localparam int WB_LEN_LSB    = 2;
    localparam int WB_UNSIGNED   = 1;
    localparam int WB_MEM_TO_REG = 0;

    // Length codes
    localparam memLen_t LEN_BYTE = 2'd0;
    localparam memLen_t LEN_HALF = 2'd1;
    localparam memLen_t LEN_WORD = 2'd2;

    // Return address register for jump and link
    localparam regIdx_t LINK_REG = 5'd31;

    // Debug register map
    localparam apbAddr_t DBG_CTRL = 4'h0;
    localparam apbAddr_t DBG_ADDR = 4'h4;
    localparam apbAddr_t DBG_DATA = 4'h8;

endpackage

`default_nettype wire

//--- hdl/memStageTop.sv
`default_nettype none

module memStageTop #(
    parameter int MEM_WORDS = 256
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // Execute stage results
    input  wire memStagePkg::wbCtrl_t  inWb,
    input  wire memStagePkg::memCtrl_t inMem,
    input  wire logic                  inJumpLink,
    input  wire memStagePkg::word_t    inLinkAddress,
    input  wire memStagePkg::word_t    inAluResult,
    input  wire memStagePkg::word_t    inStoreData,
    input  wire memStagePkg::regIdx_t  inRegWriteIdx,
    // Writeback bundle
    output memStagePkg::wbCtrl_t       outWb,
    output memStagePkg::word_t         outRegWriteData,
    output memStagePkg::word_t         outAluResult,
    output memStagePkg::regIdx_t       outRegWriteIdx,
    // Debug APB slave
    input  wire logic                  pSel,
    input  wire logic                  pEnable,
    input  wire logic                  pWrite,
    input  wire memStagePkg::apbAddr_t pAddr,
    input  wire memStagePkg::word_t    pWData,
    output memStagePkg::word_t         pRData,
    output logic                       pReady,
    output logic                       pSlvErr
);

    memStagePkg::word_t loadData;
    memStagePkg::word_t debugWord;
    memStagePkg::word_t debugAddr;
    logic               stopDebug;

    // Length and extension come from the writeback control
    dataMemory #(
        .MEM_WORDS(MEM_WORDS)
    ) dataMemory_i (
        .clk         (clk),
        .rst         (rst),
        .memCtrl     (inMem),
        .length      (inWb[memStagePkg::WB_LEN_LSB +: 2]),
        .address     (inAluResult),
        .storeData   (inStoreData),
        .loadUnsigned(inWb[memStagePkg::WB_UNSIGNED]),
        .stopDebug   (stopDebug),
        .debugAddr   (debugAddr),
        .loadData    (loadData),
        .debugWord   (debugWord)
    );

    debugApbPort debugApbPort_i (
        .clk      (clk),
        .rst      (rst),
        .pSel     (pSel),
        .pEnable  (pEnable),
        .pWrite   (pWrite),
        .pAddr    (pAddr),
        .pWData   (pWData),
        .debugWord(debugWord),
        .pRData   (pRData),
        .pReady   (pReady),
        .pSlvErr  (pSlvErr),
        .stopDebug(stopDebug),
        .debugAddr(debugAddr)
    );

    memWriteback memWriteback_i (
        .clk            (clk),
        .rst            (rst),
        .stopDebug      (stopDebug),
        .inWb           (inWb),
        .inJumpLink     (inJumpLink),
        .inLinkAddress  (inLinkAddress),
        .inAluResult    (inAluResult),
        .loadData       (loadData),
        .inRegWriteIdx  (inRegWriteIdx),
        .outWb          (outWb),
        .outRegWriteData(outRegWriteData),
        .outAluResult   (outAluResult),
        .outRegWriteIdx (outRegWriteIdx)
    );

endmodule

`default_nettype wire

//--- hdl/memWriteback.sv
`default_nettype none

module memWriteback (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 stopDebug,
    input  wire memStagePkg::wbCtrl_t inWb,
    input  wire logic                 inJumpLink,
    input  wire memStagePkg::word_t   inLinkAddress,
    input  wire memStagePkg::word_t   inAluResult,
    input  wire memStagePkg::word_t   loadData,
    input  wire memStagePkg::regIdx_t inRegWriteIdx,
    output memStagePkg::wbCtrl_t      outWb,
    output memStagePkg::word_t        outRegWriteData,
    output memStagePkg::word_t        outAluResult,
    output memStagePkg::regIdx_t      outRegWriteIdx
);

    memStagePkg::word_t   selData;
    memStagePkg::regIdx_t selIdx;

    //////////////////////////////
    // Write data select
    //////////////////////////////

    // Link overrides memToReg
    always_comb
    begin
        if (inJumpLink)
        begin
            selData = inLinkAddress;
            selIdx  = memStagePkg::LINK_REG;
        end
        else if (inWb[memStagePkg::WB_MEM_TO_REG])
        begin
            selData = loadData;
            selIdx  = inRegWriteIdx;
        end
        else
        begin
            // ALU result as write data
            selData = inAluResult;
            selIdx  = inRegWriteIdx;
        end
    end

    //////////////////////////////
    // Pipeline register
    //////////////////////////////

    // Frozen while debug stop is set
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outWb           <= '0;
            outRegWriteData <= '0;
            outAluResult    <= '0;
            outRegWriteIdx  <= '0;
        end
        else if (!stopDebug)
        begin
            outWb           <= inWb;
            outRegWriteData <= selData;
            outAluResult    <= inAluResult;
            outRegWriteIdx  <= selIdx;
        end
    end

endmodule

`default_nettype wire

//--- sim.f
hdl/memStagePkg.sv
hdl/dataMemory.sv
hdl/debugApbPort.sv
hdl/memWriteback.sv
hdl/memStageTop.sv
sim/memStage_checker.sv
sim/memStageTb.sv

//--- sim/memStageTb.sv
`default_nettype none

module memStageTb;

    localparam int MEM_WORDS     = 256;
    localparam int READY_TIMEOUT = 16;

    logic                  clk;
    logic                  rst;
    memStagePkg::wbCtrl_t  inWb;
    memStagePkg::memCtrl_t inMem;
    logic                  inJumpLink;
    memStagePkg::word_t    inLinkAddress;
    memStagePkg::word_t    inAluResult;
    memStagePkg::word_t    inStoreData;
    memStagePkg::regIdx_t  inRegWriteIdx;
    memStagePkg::wbCtrl_t  outWb;
    memStagePkg::word_t    outRegWriteData;
    memStagePkg::word_t    outAluResult;
    memStagePkg::regIdx_t  outRegWriteIdx;
    logic                  pSel;
    logic                  pEnable;
    logic                  pWrite;
    memStagePkg::apbAddr_t pAddr;
    memStagePkg::word_t    pWData;
    memStagePkg::word_t    pRData;
    logic                  pReady;
    logic                  pSlvErr;

    int                 errors = 0;
    int                 checks = 0;
    int                 tests  = 0;
    memStagePkg::word_t lfsrState = 32'hbe2f;
    // Words left in memory by the word test
    memStagePkg::word_t wordAddr [4];
    memStagePkg::word_t wordData [4];

    memStageTop #(
        .MEM_WORDS(MEM_WORDS)
    ) memStageTop_i (
        .clk(clk), .rst(rst),
        .inWb(inWb), .inMem(inMem), .inJumpLink(inJumpLink),
        .inLinkAddress(inLinkAddress), .inAluResult(inAluResult),
        .inStoreData(inStoreData), .inRegWriteIdx(inRegWriteIdx),
        .outWb(outWb), .outRegWriteData(outRegWriteData),
        .outAluResult(outAluResult), .outRegWriteIdx(outRegWriteIdx),
        .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr),
        .pWData(pWData), .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic memStagePkg::word_t lfsrNext(input memStagePkg::word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    task automatic randWord(output memStagePkg::word_t w);
        for (int i = 0; i < 32; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            w[i] = lfsrState[31];
        end
    endtask

    function automatic memStagePkg::wbCtrl_t makeWb(input logic regWrite,
            input memStagePkg::memLen_t len, input logic unsignedLoad, input logic memToReg);
        memStagePkg::wbCtrl_t wb;
        wb = '0;
        wb[memStagePkg::WB_REG_WRITE] = regWrite;
        wb[memStagePkg::WB_LEN_LSB +: 2] = len;
        wb[memStagePkg::WB_UNSIGNED] = unsignedLoad;
        wb[memStagePkg::WB_MEM_TO_REG] = memToReg;
        return wb;
    endfunction

    // Called at edge plus 2, returns one edge later with outputs settled
    task automatic pipeStep(input memStagePkg::wbCtrl_t wb, input memStagePkg::memCtrl_t mc,
            input logic jl, input memStagePkg::word_t link, input memStagePkg::word_t alu,
            input memStagePkg::word_t store, input memStagePkg::regIdx_t idx);
        inWb          = wb;
        inMem         = mc;
        inJumpLink    = jl;
        inLinkAddress = link;
        inAluResult   = alu;
        inStoreData   = store;
        inRegWriteIdx = idx;
        @(posedge clk);
        #2;
        // Idle bundle so later cycles store nothing
        inWb       = '0;
        inMem      = '0;
        inJumpLink = 1'b0;
    endtask

    task automatic storeWord(input memStagePkg::word_t addr, input memStagePkg::word_t data,
            input memStagePkg::memLen_t len);
        pipeStep(makeWb(1'b0, len, 1'b0, 1'b0), 2'b01, 1'b0, '0, addr, data, 5'd0);
    endtask

    task automatic loadWord(input memStagePkg::word_t addr, input memStagePkg::memLen_t len,
            input logic unsignedLoad);
        pipeStep(makeWb(1'b1, len, unsignedLoad, 1'b1), 2'b10, 1'b0, '0, addr, '0, 5'd3);
    endtask

    // Setup then access, error and read data taken mid access
    task automatic apbTransfer(input logic write, input memStagePkg::apbAddr_t addr,
            input memStagePkg::word_t wdata, output memStagePkg::word_t rdata,
            output logic err);
        int waitCnt;
        pSel    = 1'b1;
        pEnable = 1'b0;
        pWrite  = write;
        pAddr   = addr;
        pWData  = wdata;
        #1;
        checkBit("pReady in setup phase", pReady, 1'b0);
        @(posedge clk);
        #2;
        pEnable = 1'b1;
        #1;
        waitCnt = 0;
        while (!pReady && waitCnt < READY_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            waitCnt++;
        end
        if (!pReady)
        begin
            $display("Timeout: pReady never rose for APB offset %h", addr);
            $display("test failed");
            $finish;
        end
        else
        begin
            rdata = pRData;
            err   = pSlvErr;
            @(posedge clk);
            #2;
            pSel    = 1'b0;
            pEnable = 1'b0;
            pWrite  = 1'b0;
        end
    endtask

    task automatic apbWrite(input memStagePkg::apbAddr_t addr, input memStagePkg::word_t data,
            output logic err);
        memStagePkg::word_t unused;
        apbTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input memStagePkg::apbAddr_t addr, output memStagePkg::word_t data,
            output logic err);
        apbTransfer(1'b0, addr, '0, data, err);
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic checkWord(input string what, input memStagePkg::word_t got,
            input memStagePkg::word_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkIdx(input string what, input memStagePkg::regIdx_t got,
            input memStagePkg::regIdx_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkWb(input string what, input memStagePkg::wbCtrl_t got,
            input memStagePkg::wbCtrl_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic checkBit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        tests++;
        if (errors == errsBefore)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errsBefore);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic resetValues();
        int                 errsBefore;
        memStagePkg::word_t rd;
        logic               err;
        errsBefore = errors;
        checkWb("outWb after reset", outWb, '0);
        checkWord("outRegWriteData after reset", outRegWriteData, '0);
        checkWord("outAluResult after reset", outAluResult, '0);
        checkIdx("outRegWriteIdx after reset", outRegWriteIdx, '0);
        checkBit("pReady after reset", pReady, 1'b0);
        checkBit("pSlvErr after reset", pSlvErr, 1'b0);
        apbRead(memStagePkg::DBG_CTRL, rd, err);
        checkWord("DBG_CTRL after reset", rd, '0);
        checkBit("pSlvErr on DBG_CTRL read", err, 1'b0);
        reportTest("reset", errsBefore);
    endtask

    task automatic wordAccess();
        int                   errsBefore;
        memStagePkg::word_t   alu;
        memStagePkg::wbCtrl_t wb;
        errsBefore = errors;
        wordAddr = '{32'h10, 32'h24, 32'h3fc, 32'h200};
        for (int i = 0; i < 4; i++)
        begin
            randWord(wordData[i]);
            storeWord(wordAddr[i], wordData[i], memStagePkg::LEN_WORD);
        end
        for (int i = 0; i < 4; i++)
        begin
            wb = makeWb(1'b1, memStagePkg::LEN_WORD, 1'b0, 1'b1);
            pipeStep(wb, 2'b10, 1'b0, '0, wordAddr[i], '0, 5'(i + 1));
            checkWord("word load data", outRegWriteData, wordData[i]);
            checkWord("word load ALU result", outAluResult, wordAddr[i]);
            checkWb("word load outWb", outWb, wb);
            checkIdx("word load index", outRegWriteIdx, 5'(i + 1));
        end
        // Plain ALU operation
        randWord(alu);
        wb = makeWb(1'b1, memStagePkg::LEN_WORD, 1'b0, 1'b0);
        pipeStep(wb, 2'b00, 1'b0, '0, alu, '0, 5'd9);
        checkWord("ALU write data", outRegWriteData, alu);
        checkWb("ALU outWb", outWb, wb);
        checkIdx("ALU index", outRegWriteIdx, 5'd9);
        reportTest("word access", errsBefore);
    endtask

    task automatic byteHalfAccess();
        int                 errsBefore;
        memStagePkg::word_t base;
        memStagePkg::word_t w;
        memStagePkg::word_t r;
        memStagePkg::word_t expWord;
        logic [7:0]         b;
        logic [15:0]        h;
        errsBefore = errors;
        base = 32'h80;
        for (int o = 0; o < 4; o++)
        begin
            randWord(w);
            randWord(r);
            b = r[7:0];
            // Alternate sign bit across lanes
            b[7] = o[0];
            storeWord(base, w, memStagePkg::LEN_WORD);
            storeWord(base + o, {24'h0, b}, memStagePkg::LEN_BYTE);
            loadWord(base + o, memStagePkg::LEN_BYTE, 1'b0);
            checkWord("signed byte load", outRegWriteData, {{24{b[7]}}, b});
            loadWord(base + o, memStagePkg::LEN_BYTE, 1'b1);
            checkWord("unsigned byte load", outRegWriteData, {24'h0, b});
            expWord = w;
            expWord[8*o +: 8] = b;
            loadWord(base, memStagePkg::LEN_WORD, 1'b0);
            checkWord("word after byte store", outRegWriteData, expWord);
        end
        for (int o = 0; o < 4; o += 2)
        begin
            randWord(w);
            randWord(r);
            h = r[15:0];
            h[15] = o[1];
            storeWord(base, w, memStagePkg::LEN_WORD);
            storeWord(base + o, {16'h0, h}, memStagePkg::LEN_HALF);
            loadWord(base + o, memStagePkg::LEN_HALF, 1'b0);
            checkWord("signed half load", outRegWriteData, {{16{h[15]}}, h});
            loadWord(base + o, memStagePkg::LEN_HALF, 1'b1);
            checkWord("unsigned half load", outRegWriteData, {16'h0, h});
            expWord = w;
            expWord[8*o +: 16] = h;
            loadWord(base, memStagePkg::LEN_WORD, 1'b0);
            checkWord("word after half store", outRegWriteData, expWord);
        end
        reportTest("byte and half access", errsBefore);
    endtask

    task automatic jumpAndLink();
        int                 errsBefore;
        memStagePkg::word_t link;
        errsBefore = errors;
        randWord(link);
        // memToReg set, link still wins
        pipeStep(makeWb(1'b1, memStagePkg::LEN_WORD, 1'b0, 1'b1), 2'b10, 1'b1, link,
                 wordAddr[1], '0, 5'd5);
        checkIdx("link index", outRegWriteIdx, 5'd31);
        checkWord("link write data", outRegWriteData, link);
        pipeStep(makeWb(1'b1, memStagePkg::LEN_WORD, 1'b0, 1'b0), 2'b00, 1'b1, ~link,
                 32'h1234, '0, 5'd6);
        checkIdx("link index, ALU op", outRegWriteIdx, 5'd31);
        checkWord("link data, ALU op", outRegWriteData, ~link);
        reportTest("jump and link", errsBefore);
    endtask

    task automatic debugFreeze();
        int                   errsBefore;
        memStagePkg::word_t   rd;
        memStagePkg::word_t   newWord;
        memStagePkg::wbCtrl_t heldWb;
        memStagePkg::word_t   heldData;
        memStagePkg::word_t   heldAlu;
        memStagePkg::regIdx_t heldIdx;
        logic                 err;
        errsBefore = errors;
        apbWrite(memStagePkg::DBG_CTRL, 32'h1, err);
        checkBit("pSlvErr on stop write", err, 1'b0);
        apbRead(memStagePkg::DBG_CTRL, rd, err);
        checkWord("DBG_CTRL while stopped", rd, 32'h1);
        heldWb   = outWb;
        heldData = outRegWriteData;
        heldAlu  = outAluResult;
        heldIdx  = outRegWriteIdx;
        // Store under freeze must be dropped
        newWord = ~wordData[0];
        pipeStep(makeWb(1'b1, memStagePkg::LEN_WORD, 1'b0, 1'b0), 2'b01, 1'b0, '0,
                 wordAddr[0], newWord, 5'd7);
        loadWord(wordAddr[0], memStagePkg::LEN_WORD, 1'b0);
        checkWb("held outWb", outWb, heldWb);
        checkWord("held write data", outRegWriteData, heldData);
        checkWord("held ALU result", outAluResult, heldAlu);
        checkIdx("held index", outRegWriteIdx, heldIdx);
        // Low address bits are ignored on the debug read
        apbWrite(memStagePkg::DBG_ADDR, wordAddr[0] | 32'h3, err);
        apbRead(memStagePkg::DBG_DATA, rd, err);
        checkWord("debug memory word", rd, wordData[0]);
        checkBit("pSlvErr on DBG_DATA read", err, 1'b0);
        apbWrite(memStagePkg::DBG_CTRL, 32'h0, err);
        loadWord(wordAddr[0], memStagePkg::LEN_WORD, 1'b0);
        checkWord("load after resume", outRegWriteData, wordData[0]);
        checkWord("ALU result after resume", outAluResult, wordAddr[0]);
        reportTest("debug freeze", errsBefore);
    endtask

    task automatic apbErrors();
        int                 errsBefore;
        memStagePkg::word_t rd;
        logic               err;
        errsBefore = errors;
        apbRead(4'hc, rd, err);
        checkBit("pSlvErr on unmapped read", err, 1'b1);
        apbWrite(4'h2, 32'h1, err);
        checkBit("pSlvErr on unmapped write", err, 1'b1);
        apbWrite(memStagePkg::DBG_DATA, 32'h1, err);
        checkBit("pSlvErr on DBG_DATA write", err, 1'b1);
        apbRead(memStagePkg::DBG_CTRL, rd, err);
        checkWord("stop after errors", rd, 32'h0);
        apbRead(memStagePkg::DBG_ADDR, rd, err);
        checkWord("debug address after errors", rd, wordAddr[0] | 32'h3);
        checkBit("pSlvErr on DBG_ADDR read", err, 1'b0);
        reportTest("APB errors", errsBefore);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        rst           = 1'b1;
        inWb          = '0;
        inMem         = '0;
        inJumpLink    = 1'b0;
        inLinkAddress = '0;
        inAluResult   = '0;
        inStoreData   = '0;
        inRegWriteIdx = '0;
        pSel          = 1'b0;
        pEnable       = 1'b0;
        pWrite        = 1'b0;
        pAddr         = '0;
        pWData        = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        resetValues();
        wordAccess();
        byteHalfAccess();
        jumpAndLink();
        debugFreeze();
        apbErrors();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/memStage_checker.sv
`default_nettype none

module memStage_checker (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  pSel,
    input  wire logic                  pEnable,
    input  wire logic                  pWrite,
    input  wire memStagePkg::apbAddr_t pAddr,
    input  wire logic                  stopDebug,
    input  wire memStagePkg::wbCtrl_t  outWb,
    input  wire memStagePkg::word_t    outRegWriteData,
    input  wire memStagePkg::word_t    outAluResult,
    input  wire memStagePkg::regIdx_t  outRegWriteIdx
);

    // Stop bit moves only at the end of a DBG_CTRL write
    assert property (@(posedge clk) disable iff (rst)
        $changed(stopDebug) |->
            $past(pSel && pEnable && pWrite && (pAddr == memStagePkg::DBG_CTRL)))
        else $error("stopDebug changed without a DBG_CTRL write access");

    // Frozen writeback bundle
    assert property (@(posedge clk) disable iff (rst)
        stopDebug |=> $stable({outWb, outRegWriteData, outAluResult, outRegWriteIdx}))
        else $error("Writeback outputs moved while stopDebug was high");

    // Cleared one edge after reset
    assert property (@(posedge clk)
        rst |=> (outWb == '0 && outRegWriteData == '0 && outAluResult == '0 &&
                 outRegWriteIdx == '0))
        else $error("Writeback outputs not zero after reset");

endmodule

bind memStageTop memStage_checker memStage_checker_i (
    .clk            (clk),
    .rst            (rst),
    .pSel           (pSel),
    .pEnable        (pEnable),
    .pWrite         (pWrite),
    .pAddr          (pAddr),
    .stopDebug      (stopDebug),
    .outWb          (outWb),
    .outRegWriteData(outRegWriteData),
    .outAluResult   (outAluResult),
    .outRegWriteIdx (outRegWriteIdx)
);

`default_nettype wire
